// ==== bpInput.txt ====
# pcV pc uV s0 d0 s1 d1 uJ uC rT rP rId rBT cV cB cP cId cPc cT fl | expected:
# found taken jump dst id committed mask(b0 found b1 taken b2 jump b3 dst b4 id b5 com)
1 1000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
1 2004 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 1 1010 3000 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
1 1010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 3000 0 0 3F
0 0 3 2020 4000 2020 5000 2 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
1 2020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 5000 0 0 3D
0 0 1 3020 6000 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
1 2020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 6000 0 0 3F
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 1 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 1 0 0 0 0 0 0 1 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 6000 0 0 3F
0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 1 0 0 0 0 0 0 0 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 0 0 0 0 0 0 0 1 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 6000 0 1 3F
0 0 0 0 0 0 0 0 0 1 0 0 0 1 1 1 0 10 0 0 0 0 0 0 1 0 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 6000 0 0 3F
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 1 1 0 0 0 0 0 0 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 6000 0 0 3F
0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 0 10 1 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 31
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 31
0 0 2 0 0 40 7000 2 0 0 0 0 0 1 1 1 0 10 1 0 0 0 0 0 0 0 31
0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0 10 1 0 0 0 0 0 0 1 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 6000 0 0 3F
1 40 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 6000 1 0 3F
1 1010 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 7000 2 0 3D
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 3000 2 0 3F
0 0 0 0 0 0 0 0 0 1 1 5A 1 0 0 0 0 0 0 0 0 0 0 0 4 0 31
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 B5 0 31
0 0 0 0 0 0 0 0 0 1 0 3C 0 0 0 0 0 0 0 0 1 0 0 6000 B5 0 3F
1 3020 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 3C 0 31
0 0 0 0 0 0 0 0 0 1 1 81 0 0 0 0 0 0 0 0 1 0 0 6000 3C 0 3F
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 2 0 31

// ==== sim.f ====
bpPkg.sv
branchTargetBuffer.sv
directionTable.sv
branchPredictor.sv
tbBranchPredictor.sv

// ==== Makefile ====
SRCS := $(shell cat sim.f)

.PHONY: all run clean

all: run

obj_dir/VtbBranchPredictor: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tbBranchPredictor -f sim.f

run: obj_dir/VtbBranchPredictor
	@out=$$(./obj_dir/VtbBranchPredictor); \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// ==== tbBranchPredictor.sv ====
`default_nettype none

module tbBranchPredictor;

    import bpPkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 16;
    localparam int RESET_TIMEOUT = 64;
    localparam int NUM_FIELDS = 27;
    localparam int EXPECTED_VECTORS = 43;

    logic                               clk;
    logic                               rst;
    logic                               mispredFlush;
    logic                               pcValid;
    logic [PC_BITS-1:0]                 pc;
    logic [NUM_UPDATE-1:0]              updValid;
    logic [NUM_UPDATE-1:0][PC_BITS-1:0] updSrc;
    logic [NUM_UPDATE-1:0][PC_BITS-1:0] updDst;
    logic [NUM_UPDATE-1:0]              updIsJump;
    logic [NUM_UPDATE-1:0]              updCompr;
    logic                               resTaken;
    logic                               resPredicted;
    logic [HIST_BITS-1:0]               resBranchId;
    logic                               resBranchTaken;
    logic                               comValid;
    logic                               comIsBranch;
    logic                               comPredicted;
    logic [HIST_BITS-1:0]               comBranchId;
    logic [PC_BITS-1:0]                 comPc;
    logic                               comTaken;
    logic                               branchFound;
    logic                               branchTaken;
    logic                               isJump;
    logic                               branchCompr;
    logic [PC_BITS-1:0]                 branchSrc;
    logic [PC_BITS-1:0]                 branchDst;
    logic [HIST_BITS-1:0]               branchId;
    logic                               branchCommitted;

    logic [31:0] fld [NUM_FIELDS];
    logic [31:0] prevFld [NUM_FIELDS];
    logic        comprBySrc [logic [PC_BITS-1:0]];
    int          errorCount;
    int          vectorCount;

    branchPredictor uut (
        .clk             (clk),
        .rst             (rst),
        .mispredFlush    (mispredFlush),
        .pcValid         (pcValid),
        .pc              (pc),
        .updValid        (updValid),
        .updSrc          (updSrc),
        .updDst          (updDst),
        .updIsJump       (updIsJump),
        .updCompr        (updCompr),
        .resTaken        (resTaken),
        .resPredicted    (resPredicted),
        .resBranchId     (resBranchId),
        .resBranchTaken  (resBranchTaken),
        .comValid        (comValid),
        .comIsBranch     (comIsBranch),
        .comPredicted    (comPredicted),
        .comBranchId     (comBranchId),
        .comPc           (comPc),
        .comTaken        (comTaken),
        .branchFound     (branchFound),
        .branchTaken     (branchTaken),
        .isJump          (isJump),
        .branchCompr     (branchCompr),
        .branchSrc       (branchSrc),
        .branchDst       (branchDst),
        .branchId        (branchId),
        .branchCommitted (branchCommitted)
    );

    initial begin
        clk = 1'b0;
    end

    always begin
        #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------
    task automatic clearInputs();
        mispredFlush   = 1'b0;
        pcValid        = 1'b0;
        pc             = '0;
        updValid       = '0;
        updSrc         = '0;
        updDst         = '0;
        updIsJump      = '0;
        updCompr       = '0;
        resTaken       = 1'b0;
        resPredicted   = 1'b0;
        resBranchId    = '0;
        resBranchTaken = 1'b0;
        comValid       = 1'b0;
        comIsBranch    = 1'b0;
        comPredicted   = 1'b0;
        comBranchId    = '0;
        comPc          = '0;
        comTaken       = 1'b0;
    endtask

    // Field order follows the column header of the vector file
    task automatic applyInputs();
        pcValid        = fld[0][0];
        pc             = fld[1];
        updValid       = fld[2][NUM_UPDATE-1:0];
        updSrc[0]      = fld[3];
        updDst[0]      = fld[4];
        updSrc[1]      = fld[5];
        updDst[1]      = fld[6];
        updIsJump      = fld[7][NUM_UPDATE-1:0];
        updCompr       = fld[8][NUM_UPDATE-1:0];
        resTaken       = fld[9][0];
        resPredicted   = fld[10][0];
        resBranchId    = fld[11][HIST_BITS-1:0];
        resBranchTaken = fld[12][0];
        comValid       = fld[13][0];
        comIsBranch    = fld[14][0];
        comPredicted   = fld[15][0];
        comBranchId    = fld[16][HIST_BITS-1:0];
        comPc          = fld[17];
        comTaken       = fld[18][0];
        mispredFlush   = fld[19][0];
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // Mask bits select found, taken, jump, dst, id and committed in that order
    task automatic checkOutputs();
        logic [31:0]        mask;
        logic [PC_BITS-1:0] src;
        mask = fld[26];
        src  = {prevFld[1][PC_BITS-1:1], 1'b0};
        if (mask[0]) begin
            checkValue("branchFound", {31'b0, branchFound}, fld[20]);
        end
        // A hit also reports the looked-up source and its stored compressed flag
        if (mask[0] && fld[20][0]) begin
            checkValue("branchSrc", branchSrc, src);
            if (comprBySrc.exists(src)) begin
                checkValue("branchCompr", {31'b0, branchCompr}, {31'b0, comprBySrc[src]});
            end else begin
                $display("No update was ever driven for the branch found at %0h", src);
                errorCount++;
            end
        end
        if (mask[1]) begin
            checkValue("branchTaken", {31'b0, branchTaken}, fld[21]);
        end
        if (mask[2]) begin
            checkValue("isJump", {31'b0, isJump}, fld[22]);
        end
        if (mask[3]) begin
            checkValue("branchDst", branchDst, fld[23]);
        end
        if (mask[4]) begin
            checkValue("branchId", {24'b0, branchId}, fld[24]);
        end
        if (mask[5]) begin
            checkValue("branchCommitted", {31'b0, branchCommitted}, fld[25]);
        end
    endtask

    // Folds the previous vector's updates in once its own lookup has been checked
    task automatic recordUpdates();
        for (int i = 0; i < NUM_UPDATE; i++) begin
            if (prevFld[2][i]) begin
                comprBySrc[{prevFld[3 + 2 * i][PC_BITS-1:1], 1'b0}] = prevFld[8][i];
            end
        end
        prevFld = fld;
    endtask

    task automatic reportAndFinish();
        $display("Vectors run: %0d, errors: %0d", vectorCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // ------------------------------------------------------------
    // Reset
    // ------------------------------------------------------------
    initial begin
        rst = 1'b1;
        clearInputs();
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        rst = 1'b0;
    end

    // ------------------------------------------------------------
    // Vector loop
    // ------------------------------------------------------------
    initial begin
        int    fd;
        int    code;
        int    waitCount;
        string line;

        errorCount  = 0;
        vectorCount = 0;
        waitCount   = 0;
        foreach (prevFld[i]) begin
            prevFld[i] = '0;
        end

        fd = $fopen("bpInput.txt", "r");
        if (fd == 0) begin
            $display("Could not open the vector file bpInput.txt");
            errorCount++;
            reportAndFinish();
        end else begin
            while (rst !== 1'b0 && waitCount < RESET_TIMEOUT) begin
                @(posedge clk);
                waitCount++;
            end
            if (rst !== 1'b0) begin
                $display("Reset was still asserted after %0d cycles", RESET_TIMEOUT);
                errorCount++;
                reportAndFinish();
            end else begin
                while (!$feof(fd)) begin
                    line = "";
                    code = $fgets(line, fd);
                    if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                        code = $sscanf(line,
                            "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                            fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                            fld[15], fld[16], fld[17], fld[18], fld[19], fld[20], fld[21],
                            fld[22], fld[23], fld[24], fld[25], fld[26]);
                        if (code != NUM_FIELDS) begin
                            $display("Vector line %0d has %0d fields instead of %0d",
                                     vectorCount, code, NUM_FIELDS);
                            errorCount++;
                        end else begin
                            #10;
                            applyInputs();
                            #80;
                            checkOutputs();
                            recordUpdates();
                            vectorCount++;
                            @(posedge clk);
                        end
                    end
                end
                $fclose(fd);
                if (vectorCount < EXPECTED_VECTORS) begin
                    $display("Vector file ended early with %0d of %0d vectors",
                             vectorCount, EXPECTED_VECTORS);
                    errorCount++;
                end
                reportAndFinish();
            end
        end
    end

endmodule

`default_nettype wire

// ==== branchPredictor.sv ====
`default_nettype none

module branchPredictor (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic                                             mispredFlush,
    input  logic                                             pcValid,
    input  logic [bpPkg::PC_BITS-1:0]                        pc,
    input  logic [bpPkg::NUM_UPDATE-1:0]                     updValid,
    input  logic [bpPkg::NUM_UPDATE-1:0][bpPkg::PC_BITS-1:0] updSrc,
    input  logic [bpPkg::NUM_UPDATE-1:0][bpPkg::PC_BITS-1:0] updDst,
    input  logic [bpPkg::NUM_UPDATE-1:0]                     updIsJump,
    input  logic [bpPkg::NUM_UPDATE-1:0]                     updCompr,
    input  logic                                             resTaken,
    input  logic                                             resPredicted,
    input  logic [bpPkg::HIST_BITS-1:0]                      resBranchId,
    input  logic                                             resBranchTaken,
    input  logic                                             comValid,
    input  logic                                             comIsBranch,
    input  logic                                             comPredicted,
    input  logic [bpPkg::HIST_BITS-1:0]                      comBranchId,
    input  logic [bpPkg::PC_BITS-1:0]                        comPc,
    input  logic                                             comTaken,
    output logic                                             branchFound,
    output logic                                             branchTaken,
    output logic                                             isJump,
    output logic                                             branchCompr,
    output logic [bpPkg::PC_BITS-1:0]                        branchSrc,
    output logic [bpPkg::PC_BITS-1:0]                        branchDst,
    output logic [bpPkg::HIST_BITS-1:0]                      branchId,
    output logic                                             branchCommitted
);

    import bpPkg::*;

    logic                 selValid;
    logic [PC_BITS-1:0]   selSrc;
    logic [PC_BITS-1:0]   selDst;
    logic                 selIsJump;
    logic                 selCompr;

    logic [HIST_BITS-1:0] history;
    logic [HIST_BITS-1:0] fetchIdx;
    logic [HIST_BITS-1:0] readIdx;
    logic [HIST_BITS-1:0] commitIdx;
    logic                 commitWrite;
    logic                 condFound;

    // ------------------------------------------------------------
    // Update selection
    // ------------------------------------------------------------
    // Later units overwrite earlier ones, so the highest valid index wins
    always_comb begin
        selValid  = 1'b0;
        selSrc    = '0;
        selDst    = '0;
        selIsJump = 1'b0;
        selCompr  = 1'b0;
        for (int i = 0; i < NUM_UPDATE; i++) begin
            if (updValid[i]) begin
                selValid  = 1'b1;
                selSrc    = updSrc[i];
                selDst    = updDst[i];
                selIsJump = updIsJump[i];
                selCompr  = updCompr[i];
            end
        end
    end

    branchTargetBuffer btb (
        .clk         (clk),
        .rst         (rst),
        .pcValid     (pcValid),
        .pc          (pc),
        .updValid    (selValid),
        .updIsJump   (selIsJump),
        .updCompr    (selCompr),
        .updSrc      (selSrc),
        .updDst      (selDst),
        .branchFound (branchFound),
        .isJump      (isJump),
        .branchCompr (branchCompr),
        .branchSrc   (branchSrc),
        .branchDst   (branchDst)
    );

    // ------------------------------------------------------------
    // Gshare indexing
    // ------------------------------------------------------------
    // An uncompressed branch is indexed by the halfword before its source
    assign fetchIdx = branchCompr ? branchSrc[HIST_BITS:1] : branchSrc[HIST_BITS:1] - 1'b1;
    assign readIdx  = fetchIdx ^ history;

    assign commitIdx   = comBranchId ^ comPc[HIST_BITS-1:0];
    assign commitWrite = comValid && comIsBranch && comPredicted && !mispredFlush;

    directionTable dirTable (
        .clk        (clk),
        .rst        (rst),
        .writeEn    (commitWrite),
        .writeTaken (comTaken),
        .readAddr   (readIdx),
        .writeAddr  (commitIdx),
        .taken      (branchTaken)
    );

    // ------------------------------------------------------------
    // Global history and commit strobe
    // ------------------------------------------------------------
    assign condFound = branchFound && !isJump;
    assign branchId  = history;

    // Repair from the resolution port beats the speculative shift
    always_ff @(posedge clk) begin
        if (rst) begin
            history <= '0;
        end else if (resTaken) begin
            if (resPredicted) begin
                history <= {resBranchId[HIST_BITS-2:0], resBranchTaken};
            end else begin
                history <= resBranchId;
            end
        end else if (condFound) begin
            history <= {history[HIST_BITS-2:0], branchTaken};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            branchCommitted <= 1'b0;
        end else begin
            branchCommitted <= comValid && comIsBranch && !mispredFlush;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (!condFound && !resTaken) |=> $stable(history))
    else $error("Global history moved without a branch or a repair");

endmodule

`default_nettype wire

// ==== directionTable.sv ====
`default_nettype none

module directionTable (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        writeEn,
    input  logic                        writeTaken,
    input  logic [bpPkg::HIST_BITS-1:0] readAddr,
    input  logic [bpPkg::HIST_BITS-1:0] writeAddr,
    output logic                        taken
);

    import bpPkg::*;

    localparam int NUM_COUNTERS = 2 ** HIST_BITS;

    logic [1:0] counters [NUM_COUNTERS];
    logic [1:0] writeOld;

    // Upper bit of a two-bit counter is the prediction
    assign taken = counters[readAddr][1];

    assign writeOld = counters[writeAddr];

    // ------------------------------------------------------------
    // Saturating update at commit
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_COUNTERS; i++) begin
                counters[i] <= CNT_INIT;
            end
        end else if (writeEn) begin
            if (writeTaken) begin
                if (writeOld != 2'b11) begin
                    counters[writeAddr] <= writeOld + 2'b01;
                end
            end else begin
                if (writeOld != 2'b00) begin
                    counters[writeAddr] <= writeOld - 2'b01;
                end
            end
        end
    end

    // An unknown index here would corrupt a whole range of counters
    assert property (@(posedge clk) disable iff (rst)
        writeEn |-> !$isunknown(writeAddr))
    else $error("Direction table written with unknown index");

endmodule

`default_nettype wire

// ==== branchTargetBuffer.sv ====
`default_nettype none

module branchTargetBuffer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pcValid,
    input  logic [bpPkg::PC_BITS-1:0] pc,
    input  logic                      updValid,
    input  logic                      updIsJump,
    input  logic                      updCompr,
    input  logic [bpPkg::PC_BITS-1:0] updSrc,
    input  logic [bpPkg::PC_BITS-1:0] updDst,
    output logic                      branchFound,
    output logic                      isJump,
    output logic                      branchCompr,
    output logic [bpPkg::PC_BITS-1:0] branchSrc,
    output logic [bpPkg::PC_BITS-1:0] branchDst
);

    import bpPkg::*;

    // ------------------------------------------------------------
    // Entry storage
    // ------------------------------------------------------------
    logic                      entryValid [BTB_ENTRIES];
    logic [BTB_TAG_BITS-1:0]   entryTag   [BTB_ENTRIES];
    logic [PC_BITS-2:0]        entryDst   [BTB_ENTRIES];
    logic                      entryJump  [BTB_ENTRIES];
    logic                      entryCompr [BTB_ENTRIES];

    logic [BTB_INDEX_BITS-1:0] lookupIdx;
    logic [BTB_TAG_BITS-1:0]   lookupTag;
    logic [BTB_INDEX_BITS-1:0] updIdx;
    logic [BTB_TAG_BITS-1:0]   updTag;
    logic                      lookupHit;

    // Output payload, address bit 0 is appended as zero
    logic [PC_BITS-2:0]        srcHi;
    logic [PC_BITS-2:0]        dstHi;

    assign lookupIdx = pc[BTB_INDEX_BITS:1];
    assign lookupTag = pc[PC_BITS-1:BTB_INDEX_BITS+1];
    assign updIdx    = updSrc[BTB_INDEX_BITS:1];
    assign updTag    = updSrc[PC_BITS-1:BTB_INDEX_BITS+1];

    assign lookupHit = entryValid[lookupIdx] && (entryTag[lookupIdx] == lookupTag);

    assign branchSrc = {srcHi, 1'b0};
    assign branchDst = {dstHi, 1'b0};

    // Valid bits are the only part of an entry that needs clearing
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (updValid) begin
            entryValid[updIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (updValid) begin
            entryTag[updIdx]   <= updTag;
            entryDst[updIdx]   <= updDst[PC_BITS-1:1];
            entryJump[updIdx]  <= updIsJump;
            entryCompr[updIdx] <= updCompr;
        end
    end

    // ------------------------------------------------------------
    // Registered lookup
    // ------------------------------------------------------------
    // Outputs hold until the next lookup, an idle fetch drops the hit
    always_ff @(posedge clk) begin
        if (rst) begin
            branchFound <= 1'b0;
            isJump      <= 1'b0;
            branchCompr <= 1'b0;
            srcHi       <= '0;
            dstHi       <= '0;
        end else if (pcValid) begin
            branchFound <= lookupHit;
            isJump      <= entryJump[lookupIdx];
            branchCompr <= entryCompr[lookupIdx];
            srcHi       <= {entryTag[lookupIdx], lookupIdx};
            dstHi       <= entryDst[lookupIdx];
        end else begin
            branchFound <= 1'b0;
        end
    end

    // A freshly written entry must be visible to a lookup on the following cycle
    assert property (@(posedge clk) disable iff (rst)
        updValid ##1 (pcValid && pc[PC_BITS-1:1] == $past(updSrc[PC_BITS-1:1]))
        |=> branchFound)
    else $error("Target buffer missed an entry written two cycles earlier");

endmodule

`default_nettype wire

// ==== bpPkg.sv ====
`default_nettype none

package bpPkg;

    // ------------------------------------------------------------
    // Address and history widths
    // ------------------------------------------------------------
    localparam int PC_BITS = 32;

    // Global history, branch ID and direction-table index share one width
    localparam int HIST_BITS = 8;

    // ------------------------------------------------------------
    // Target buffer geometry
    // ------------------------------------------------------------
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_INDEX_BITS = $clog2(BTB_ENTRIES);

    // Index comes from pc[BTB_INDEX_BITS:1], bit 0 is never stored
    localparam int BTB_TAG_BITS = PC_BITS - BTB_INDEX_BITS - 1;

    // Branch execution units able to write the target buffer
    localparam int NUM_UPDATE = 2;

    // Counters start weakly not taken
    localparam logic [1:0] CNT_INIT = 2'b01;

endpackage

`default_nettype wire
